//--- flist.f
rtl/dbg_ram_pkg.sv
rtl/wb_burst_adr_gen.sv
rtl/wb_ram_b3.sv
rtl/dbg_wb_master.sv
rtl/dbg_ram_top.sv
verif/dbg_ram_tb.sv

//--- rtl/dbg_ram_pkg.sv
// Bus and memory sizes, cycle and burst type codes, bus and command structs, burst address rule
package dbg_ram_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////

  // Wishbone data and address width
  localparam int DW = 32;
  localparam int AW = 32;
  // Byte selects per data word
  localparam int SW = DW / 8;

  // 4 KB of memory, byte addressed
  localparam int MEM_ADR_WIDTH = 12;
  localparam int MEM_WORDS = 1024;
  // Word address inside the memory
  localparam int WADR_W = MEM_ADR_WIDTH - 2;
  // Word address on the bus
  localparam int BUS_WADR_W = AW - 2;
  // Top nibble of the bus address is outside the range check
  localparam int ADR_CHK_MSB = AW - 5;

  // Beat count field of a debug command
  localparam int LEN_W = 4;

  //////////////////////////////////////////////////////////////////////
  // Cycle and burst type codes
  //////////////////////////////////////////////////////////////////////

  localparam logic [2:0] CTI_CLASSIC = 3'b000;
  localparam logic [2:0] CTI_CONST   = 3'b001;
  localparam logic [2:0] CTI_INCR    = 3'b010;
  localparam logic [2:0] CTI_END     = 3'b111;

  localparam logic [1:0] BTE_LINEAR = 2'd0;
  localparam logic [1:0] BTE_WRAP4  = 2'd1;
  localparam logic [1:0] BTE_WRAP8  = 2'd2;
  localparam logic [1:0] BTE_WRAP16 = 2'd3;

  //////////////////////////////////////////////////////////////////////
  // Bundles
  //////////////////////////////////////////////////////////////////////

  // Master to slave
  typedef struct packed {
    logic [AW-1:0] adr;
    logic [DW-1:0] dat;
    logic [SW-1:0] sel;
    logic          we;
    logic [1:0]    bte;
    logic [2:0]    cti;
    logic          cyc;
    logic          stb;
  } wb_m2s_t;

  // Slave to master, no retry line
  typedef struct packed {
    logic [DW-1:0] dat;
    logic          ack;
    logic          err;
  } wb_s2m_t;

  // One debug request
  typedef struct packed {
    logic [AW-1:0]    adr;    // start byte address
    logic [SW-1:0]    sel;
    logic             we;
    logic [LEN_W-1:0] len;    // beats minus one
    logic             burst;  // 1 incrementing, 0 constant address
    logic [1:0]       bte;
  } dbg_cmd_t;

  //////////////////////////////////////////////////////////////////////
  // Burst address rule
  //////////////////////////////////////////////////////////////////////

  // Next word address of an incrementing burst
  // Wrap modes only step the low 2, 3 or 4 bits
  function automatic logic [BUS_WADR_W-1:0] burst_next_wadr(
    input logic [BUS_WADR_W-1:0] wadr,
    input logic [1:0]            bte
  );
    logic [BUS_WADR_W-1:0] nxt;
    nxt = wadr;
    case (bte)
      BTE_LINEAR: nxt = wadr + 1'b1;
      BTE_WRAP4:  nxt[1:0] = wadr[1:0] + 2'd1;
      BTE_WRAP8:  nxt[2:0] = wadr[2:0] + 3'd1;
      BTE_WRAP16: nxt[3:0] = wadr[3:0] + 4'd1;
    endcase
    return nxt;
  endfunction

endpackage

//--- rtl/dbg_ram_top.sv
// Debug memory subsystem top with the Wishbone master and the RAM slave
`timescale 1ns/10ps

module dbg_ram_top (
  input  logic                       wb_clk_i,
  input  logic                       wb_rst_i,

  // Command port
  input  logic                       cmd_valid_i,
  input  dbg_ram_pkg::dbg_cmd_t      cmd_i,
  output logic                       busy_o,

  // Data port
  input  logic [dbg_ram_pkg::DW-1:0] wr_data_i,
  output logic                       wr_beat_o,
  output logic                       rd_valid_o,
  output logic [dbg_ram_pkg::DW-1:0] rd_data_o,

  // Completion
  output logic                       done_o,
  output logic                       err_o
);

  import dbg_ram_pkg::*;

  // Wishbone bus between master and slave
  wb_m2s_t m2s;
  wb_s2m_t s2m;

  dbg_wb_master dbg_wb_master_inst (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .wr_data_i   (wr_data_i),
    .s2m_i       (s2m),
    .m2s_o       (m2s),
    .busy_o      (busy_o),
    .rd_valid_o  (rd_valid_o),
    .rd_data_o   (rd_data_o),
    .wr_beat_o   (wr_beat_o),
    .done_o      (done_o),
    .err_o       (err_o)
  );

  wb_ram_b3 wb_ram_b3_inst (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .m2s_i    (m2s),
    .s2m_o    (s2m)
  );

endmodule

//--- rtl/dbg_wb_master.sv
// Debug command to Wishbone B3 master, single and burst cycles with beat count and address step
`timescale 1ns/10ps

module dbg_wb_master (
  input  logic                       wb_clk_i,
  input  logic                       wb_rst_i,
  input  logic                       cmd_valid_i,
  input  dbg_ram_pkg::dbg_cmd_t      cmd_i,
  input  logic [dbg_ram_pkg::DW-1:0] wr_data_i,
  input  dbg_ram_pkg::wb_s2m_t       s2m_i,
  output dbg_ram_pkg::wb_m2s_t       m2s_o,
  output logic                       busy_o,
  output logic                       rd_valid_o,
  output logic [dbg_ram_pkg::DW-1:0] rd_data_o,
  output logic                       wr_beat_o,
  output logic                       done_o,
  output logic                       err_o
);

  import dbg_ram_pkg::*;

  // Control state
  logic                  busy_r;
  logic                  cyc_r;
  logic                  done_r;
  logic                  err_r;
  // Beats left after the current one
  logic [LEN_W-1:0]      cnt_r;

  // Latched command
  logic [AW-1:0]         adr_r;
  logic [SW-1:0]         sel_r;
  logic                  we_r;
  logic [1:0]            bte_r;
  logic                  incr_r;
  // More than one beat
  logic                  multi_r;

  logic [2:0]            cti;
  logic [BUS_WADR_W-1:0] wadr_next;
  logic                  accept;
  logic                  beat_ack;
  logic                  last_beat;
  logic                  finish;

  //////////////////////////////////////////////////////////////////////
  // Command accept and cycle end
  //////////////////////////////////////////////////////////////////////

  // Strobes while busy are dropped
  assign accept    = cmd_valid_i & ~busy_r;
  assign beat_ack  = cyc_r & s2m_i.ack;
  assign last_beat = (cnt_r == '0);
  // Error ends the cycle at once
  assign finish    = cyc_r & (s2m_i.err | (s2m_i.ack & last_beat));

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      busy_r <= 1'b0;
      cyc_r  <= 1'b0;
      done_r <= 1'b0;
      err_r  <= 1'b0;
      cnt_r  <= '0;
    end else begin
      done_r <= finish;
      if (accept) begin
        busy_r <= 1'b1;
        cyc_r  <= 1'b1;
        err_r  <= 1'b0;
        cnt_r  <= cmd_i.len;
      end else begin
        if (finish) begin
          cyc_r <= 1'b0;
          err_r <= s2m_i.err;
        end else if (beat_ack) begin
          cnt_r <= cnt_r - 1'b1;
        end
        // Busy covers the done cycle too
        if (done_r) begin
          busy_r <= 1'b0;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Command payload and address step
  //////////////////////////////////////////////////////////////////////

  assign wadr_next = burst_next_wadr(adr_r[AW-1:2], bte_r);

  always_ff @(posedge wb_clk_i) begin
    if (accept) begin
      adr_r   <= cmd_i.adr;
      sel_r   <= cmd_i.sel;
      we_r    <= cmd_i.we;
      bte_r   <= cmd_i.bte;
      incr_r  <= cmd_i.burst;
      multi_r <= |cmd_i.len;
    end else if (beat_ack & incr_r & ~last_beat) begin
      // Same step as the slave, constant bursts keep the address
      adr_r[AW-1:2] <= wadr_next;
    end
  end

  // Cycle type of the beat on the bus
  always_comb begin
    if (!multi_r) begin
      cti = CTI_CLASSIC;
    end else if (last_beat) begin
      cti = CTI_END;
    end else if (incr_r) begin
      cti = CTI_INCR;
    end else begin
      cti = CTI_CONST;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////////////////////////

  // Write data goes straight through, source keeps pace with wr_beat_o
  assign m2s_o = '{adr: adr_r,
                   dat: wr_data_i,
                   sel: sel_r,
                   we:  we_r,
                   bte: bte_r,
                   cti: cti,
                   cyc: cyc_r,
                   stb: cyc_r};

  assign busy_o     = busy_r;
  assign rd_valid_o = beat_ack & ~we_r;
  assign rd_data_o  = s2m_i.dat;
  assign wr_beat_o  = beat_ack & we_r;
  assign done_o     = done_r;
  assign err_o      = err_r;

endmodule

//--- rtl/wb_burst_adr_gen.sv
// Burst flag, registered cycle and burst type, and word address register of the RAM slave
`timescale 1ns/10ps

module wb_burst_adr_gen (
  input  logic                           wb_clk_i,
  input  logic                           wb_rst_i,
  input  dbg_ram_pkg::wb_m2s_t           m2s_i,
  input  logic                           ack_i,
  input  logic                           err_i,
  output logic [dbg_ram_pkg::WADR_W-1:0] adr_o,
  output logic                           burst_o
);

  import dbg_ram_pkg::*;

  // Burst in progress
  logic                  burst_r;
  // Cycle and burst type of the previous cycle
  logic [2:0]            cti_r;
  logic [1:0]            bte_r;
  // Word address presented to the memory
  logic [WADR_W-1:0]     adr_r;
  logic [WADR_W-1:0]     adr_nxt;
  logic [BUS_WADR_W-1:0] wadr_wrap;
  logic                  burst_start;
  logic                  burst_stop;

  //////////////////////////////////////////////////////////////////////
  // Burst tracking
  //////////////////////////////////////////////////////////////////////

  // First strobe of a constant or incrementing burst
  assign burst_start = m2s_i.cyc & m2s_i.stb & ~burst_r &
                       ((m2s_i.cti == CTI_CONST) | (m2s_i.cti == CTI_INCR));

  // Last beat acked, or any error
  assign burst_stop = ((m2s_i.cti == CTI_END) & m2s_i.stb & burst_r & ack_i) | err_i;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      burst_r <= 1'b0;
    end else if (burst_start) begin
      burst_r <= 1'b1;
    end else if (burst_stop) begin
      burst_r <= 1'b0;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      cti_r <= CTI_CLASSIC;
      bte_r <= BTE_LINEAR;
    end else begin
      cti_r <= m2s_i.cti;
      bte_r <= m2s_i.bte;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Word address
  //////////////////////////////////////////////////////////////////////

  assign wadr_wrap = burst_next_wadr(BUS_WADR_W'(adr_r), bte_r);

  // Step only on an acked incrementing beat, constant bursts hold
  assign adr_nxt = ((cti_r == CTI_INCR) & ack_i) ? wadr_wrap[WADR_W-1:0] : adr_r;

  // Bursts follow their own count
  // otherwise the bus address is taken on every strobe
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      adr_r <= '0;
    end else if (burst_r) begin
      adr_r <= adr_nxt;
    end else if (m2s_i.cyc & m2s_i.stb) begin
      adr_r <= m2s_i.adr[MEM_ADR_WIDTH-1:2];
    end
  end

  assign adr_o   = adr_r;
  assign burst_o = burst_r;

endmodule

//--- rtl/wb_ram_b3.sv
// Wishbone B3 block RAM slave with registered ack, error detection and byte-merge writes
`timescale 1ns/10ps

module wb_ram_b3 (
  input  logic                 wb_clk_i,
  input  logic                 wb_rst_i,
  input  dbg_ram_pkg::wb_m2s_t m2s_i,
  output dbg_ram_pkg::wb_s2m_t s2m_o
);

  import dbg_ram_pkg::*;

  // Memory array, one word per entry
  logic [DW-1:0]     mem [MEM_WORDS];

  // Word address and burst flag from the tracker
  logic [WADR_W-1:0] adr;
  logic              burst;

  // Registered feedback ack
  logic              ack_r;
  logic              ack;
  logic              err;

  // Error sources
  logic              adr_err;
  logic              burst_adr_err;

  logic              ram_we;
  logic [DW-1:0]     rd_data;
  logic [DW-1:0]     wr_data;

  //////////////////////////////////////////////////////////////////////
  // Burst address tracker
  //////////////////////////////////////////////////////////////////////

  wb_burst_adr_gen wb_burst_adr_gen_inst (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .m2s_i    (m2s_i),
    .ack_i    (ack),
    .err_i    (err),
    .adr_o    (adr),
    .burst_o  (burst)
  );

  //////////////////////////////////////////////////////////////////////
  // Error checks
  //////////////////////////////////////////////////////////////////////

  // Outside the 4 KB, top nibble may hold a base and is not checked
  assign adr_err = m2s_i.cyc & m2s_i.stb & (|m2s_i.adr[ADR_CHK_MSB:MEM_ADR_WIDTH]);

  // Master address no longer matches the burst count
  assign burst_adr_err = burst & (adr != m2s_i.adr[MEM_ADR_WIDTH-1:2]);

  //////////////////////////////////////////////////////////////////////
  // Ack and error
  //////////////////////////////////////////////////////////////////////

  // Error takes the slot the ack would have had
  assign ack = ack_r & m2s_i.stb & ~(burst_adr_err | adr_err);
  assign err = ack_r & m2s_i.stb & (burst_adr_err | adr_err);

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_r <= 1'b0;
    end else if (!m2s_i.cyc) begin
      ack_r <= 1'b0;
    end else if (adr_err) begin
      // Answer a bad address on the next cycle
      ack_r <= 1'b1;
    end else begin
      case (m2s_i.cti)
        // Single access, ack toggles so stb can drop after it
        CTI_CLASSIC: ack_r <= m2s_i.stb ^ ack_r;
        // Burst beats ack back to back
        CTI_CONST,
        CTI_INCR:    ack_r <= m2s_i.stb;
        // Last beat, no ack past it
        CTI_END:     ack_r <= m2s_i.stb & ~ack_r;
        // Reserved cycle types get no answer
        default:     ack_r <= 1'b0;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Memory
  //////////////////////////////////////////////////////////////////////

  assign rd_data = mem[adr];

  // Read-modify-write merge of selected bytes
  always_comb begin
    for (int b = 0; b < SW; b++) begin
      wr_data[8*b +: 8] = m2s_i.sel[b] ? m2s_i.dat[8*b +: 8] : rd_data[8*b +: 8];
    end
  end

  // Write only on an acked beat
  assign ram_we = m2s_i.we & ack;

  always_ff @(posedge wb_clk_i) begin
    if (ram_we) begin
      mem[adr] <= wr_data;
    end
  end

  assign s2m_o = '{dat: rd_data, ack: ack, err: err};

endmodule

//--- run.sh
#!/bin/sh
# Build the debug memory testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module dbg_ram_tb -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vdbg_ram_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "all tests passed"; then
  exit 0
fi
exit 1

//--- verif/dbg_ram_tb.sv
// Debug memory subsystem testbench with clock, reset, memory model, command tasks and checks
`timescale 1ns/10ps

module dbg_ram_tb;

  import dbg_ram_pkg::*;

  localparam int CLK_PERIOD     = 100;
  localparam int DRIVE_DLY      = 5;
  localparam int RESET_CYCLES   = 10;
  // Fill, directed and random commands need well under a thousand cycles
  localparam int TIMEOUT_CYCLES = 3000;

  logic          wb_clk_i;
  logic          wb_rst_i;
  logic          cmd_valid_i;
  dbg_cmd_t      cmd_i;
  logic [DW-1:0] wr_data_i;
  logic          busy_o;
  logic          wr_beat_o;
  logic          rd_valid_o;
  logic [DW-1:0] rd_data_o;
  logic          done_o;
  logic          err_o;

  // Reference memory and per-command expectations
  logic [DW-1:0] model [MEM_WORDS];
  logic [DW-1:0] wdata [16];
  logic [DW-1:0] exp_rd [16];
  logic [DW-1:0] exp_word;
  logic [4:0]    rd_idx;
  logic          exp_err;
  // High from reset release until the first command
  logic          quiet;

  int     err_cnt = 0;
  int     err_snap = 0;
  int     cycles = 0;
  int     test_num = 0;
  int     pass_cnt = 0;
  int     fail_cnt = 0;
  string  test_name;
  integer seed;

  dbg_ram_top dbg_ram_top_inst (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .busy_o      (busy_o),
    .wr_data_i   (wr_data_i),
    .wr_beat_o   (wr_beat_o),
    .rd_valid_o  (rd_valid_o),
    .rd_data_o   (rd_data_o),
    .done_o      (done_o),
    .err_o       (err_o)
  );

  initial wb_clk_i = 1'b0;
  always #(CLK_PERIOD / 2) wb_clk_i = ~wb_clk_i;

  // Run limit
  always @(posedge wb_clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the DUT never finished the command", cycles);
      $display("tests failed");
      $finish;
    end
  end

  // Next expected read word, restarts with each command
  always @(posedge wb_clk_i) begin
    if (wb_rst_i | cmd_valid_i) begin
      rd_idx <= '0;
    end else if (rd_valid_o) begin
      rd_idx <= rd_idx + 5'd1;
    end
  end

  assign exp_word = exp_rd[rd_idx[3:0]];

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  rd_data_chk: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    rd_valid_o |-> ((rd_idx < 5'd16) && (rd_data_o == exp_word)))
    else begin
      $display("Mismatch rd_data_o: got %h expected %h", $sampled(rd_data_o),
               $sampled(exp_word));
      err_cnt++;
    end

  // Error only for a set bit in 27..12
  err_chk: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    done_o |-> (err_o == exp_err))
    else begin
      $display("Mismatch err_o: got %h expected %h", $sampled(err_o), $sampled(exp_err));
      err_cnt++;
    end

  quiet_chk: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    quiet |-> !(busy_o | done_o | rd_valid_o | wr_beat_o | err_o))
    else begin
      $display("Mismatch busy/done/rd_valid/wr_beat/err: got %h expected 00",
               $sampled({busy_o, done_o, rd_valid_o, wr_beat_o, err_o}));
      err_cnt++;
    end

  //////////////////////////////////////////////////////////////////////
  // Model helpers
  //////////////////////////////////////////////////////////////////////

  // Next burst word wrapping inside the aligned block
  function automatic logic [WADR_W-1:0] step_word(input logic [WADR_W-1:0] w,
                                                  input logic [1:0] bte, input logic incr);
    logic [WADR_W-1:0] mask;
    case (bte)
      BTE_WRAP4:  mask = 10'h003;
      BTE_WRAP8:  mask = 10'h007;
      BTE_WRAP16: mask = 10'h00f;
      default:    mask = 10'h3ff;
    endcase
    if (!incr) begin
      return w;
    end
    return (w & ~mask) | ((w + 10'd1) & mask);
  endfunction

  // New bytes under sel and old bytes elsewhere
  function automatic logic [DW-1:0] merge_bytes(input logic [DW-1:0] old_w,
                                                input logic [DW-1:0] new_w,
                                                input logic [SW-1:0] sel);
    logic [DW-1:0] keep;
    keep = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    return (new_w & keep) | (old_w & ~keep);
  endfunction

  // Address dependent fill
  function automatic logic [DW-1:0] fill_word(input logic [WADR_W-1:0] w);
    return {~w, 6'h15, w, 6'h2a};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Command and test bookkeeping
  //////////////////////////////////////////////////////////////////////

  // Runs one debug command against a model updated first and waits for done_o
  task automatic run_cmd(input logic [AW-1:0] adr, input logic [SW-1:0] sel, input logic we,
                         input logic [LEN_W-1:0] len, input logic burst, input logic [1:0] bte);
    logic [WADR_W-1:0] w;
    logic wb;
    logic rv;
    logic dn;
    int   beats;
    int   wr_seen;
    int   rd_seen;
    int   done_seen;
    exp_err = |adr[27:12];
    beats = exp_err ? 0 : int'(len) + 1;
    w = adr[MEM_ADR_WIDTH-1:2];
    for (int i = 0; i < beats; i++) begin
      if (we) begin
        model[w] = merge_bytes(model[w], wdata[i], sel);
      end else begin
        exp_rd[i] = model[w];
      end
      w = step_word(w, bte, burst);
    end
    wr_seen = 0;
    rd_seen = 0;
    done_seen = 0;
    @(posedge wb_clk_i);
    #DRIVE_DLY;
    quiet = 1'b0;
    cmd_i = '{adr: adr, sel: sel, we: we, len: len, burst: burst, bte: bte};
    cmd_valid_i = 1'b1;
    wr_data_i = wdata[0];
    while (done_seen == 0) begin
      @(negedge wb_clk_i);
      wb = wr_beat_o;
      rv = rd_valid_o;
      dn = done_o;
      @(posedge wb_clk_i);
      #DRIVE_DLY;
      cmd_valid_i = 1'b0;
      // Next write word before the following edge
      if (wb) begin
        wr_seen++;
        wr_data_i = wdata[wr_seen[3:0]];
      end
      if (rv) begin
        rd_seen++;
      end
      if (dn) begin
        done_seen++;
      end
    end
    @(negedge wb_clk_i);
    if (done_o) begin
      done_seen++;
    end
    assert (done_seen == 1) else begin
      $display("Mismatch done_o pulses: got %h expected %h", done_seen, 1);
      err_cnt++;
    end
    assert (wr_seen == (we ? beats : 0)) else begin
      $display("Mismatch wr_beat_o pulses: got %h expected %h", wr_seen, we ? beats : 0);
      err_cnt++;
    end
    assert (rd_seen == (we ? 0 : beats)) else begin
      $display("Mismatch rd_valid_o pulses: got %h expected %h", rd_seen, we ? 0 : beats);
      err_cnt++;
    end
  endtask

  // Wrap write mid-block then wrap and linear read-back
  task automatic wrap_case(input logic [WADR_W-1:0] start, input logic [WADR_W-1:0] base,
                           input logic [1:0] bte, input logic [LEN_W-1:0] len);
    logic [WADR_W-1:0] w;
    w = start;
    for (int i = 0; i <= int'(len); i++) begin
      wdata[i] = ~fill_word(w);
      w = step_word(w, bte, 1'b1);
    end
    run_cmd({20'h0, start, 2'b00}, 4'hf, 1'b1, len, 1'b1, bte);
    run_cmd({20'h0, start, 2'b00}, 4'hf, 1'b0, len, 1'b1, bte);
    run_cmd({20'h0, base, 2'b00}, 4'hf, 1'b0, len, 1'b1, BTE_LINEAR);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_num++;
    err_snap = err_cnt;
  endtask

  task automatic end_test();
    if (err_cnt == err_snap) begin
      pass_cnt++;
      $display("test %0d %s: PASS", test_num, test_name);
    end else begin
      fail_cnt++;
      $display("test %0d %s: FAIL", test_num, test_name);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0]       r;
    logic [WADR_W-1:0] w;
    seed = 32'h4d6639ed;
    wb_rst_i = 1'b1;
    cmd_valid_i = 1'b0;
    cmd_i = '0;
    wr_data_i = '0;
    exp_err = 1'b0;
    quiet = 1'b0;
    repeat (RESET_CYCLES) @(posedge wb_clk_i);
    #DRIVE_DLY;
    wb_rst_i = 1'b0;
    quiet = 1'b1;

    begin_test("quiet after reset");
    repeat (5) @(posedge wb_clk_i);
    end_test();

    begin_test("partial select write");
    wdata[0] = 32'h11223344;
    run_cmd(32'h0000_0100, 4'hf, 1'b1, 4'd0, 1'b0, BTE_LINEAR);
    wdata[0] = 32'haabbccdd;
    run_cmd(32'h0000_0100, 4'b0101, 1'b1, 4'd0, 1'b0, BTE_LINEAR);
    run_cmd(32'h0000_0100, 4'hf, 1'b0, 4'd0, 1'b0, BTE_LINEAR);
    end_test();

    begin_test("linear burst");
    w = 10'h080;
    for (int i = 0; i < 8; i++) begin
      wdata[i] = fill_word(w);
      w = w + 10'd1;
    end
    run_cmd(32'h0000_0200, 4'hf, 1'b1, 4'd7, 1'b1, BTE_LINEAR);
    run_cmd(32'h0000_0200, 4'hf, 1'b0, 4'd7, 1'b1, BTE_LINEAR);
    end_test();

    begin_test("wrap bursts");
    wrap_case(10'h0c2, 10'h0c0, BTE_WRAP4, 4'd3);
    wrap_case(10'h0d5, 10'h0d0, BTE_WRAP8, 4'd7);
    wrap_case(10'h0e9, 10'h0e0, BTE_WRAP16, 4'd15);
    end_test();

    begin_test("address error");
    wdata[0] = 32'hdeadbeef;
    run_cmd(32'h0000_1100, 4'hf, 1'b1, 4'd0, 1'b0, BTE_LINEAR);
    run_cmd(32'h0800_0100, 4'hf, 1'b0, 4'd0, 1'b0, BTE_LINEAR);
    run_cmd(32'h0000_2200, 4'hf, 1'b0, 4'd3, 1'b1, BTE_LINEAR);
    run_cmd(32'h0000_0100, 4'hf, 1'b0, 4'd0, 1'b0, BTE_LINEAR);
    // Top nibble outside the check
    run_cmd(32'hf000_0100, 4'hf, 1'b0, 4'd0, 1'b0, BTE_LINEAR);
    end_test();

    begin_test("random singles");
    w = 10'h100;
    for (int i = 0; i < 16; i++) begin
      wdata[i] = fill_word(w);
      w = w + 10'd1;
    end
    run_cmd(32'h0000_0400, 4'hf, 1'b1, 4'd15, 1'b1, BTE_LINEAR);
    for (int i = 0; i < 40; i++) begin
      r = $random(seed);
      wdata[0] = $random(seed);
      w = {6'h10, r[3:0]};
      run_cmd({20'h0, w, 2'b00}, r[7:4], r[8], 4'd0, 1'b0, BTE_LINEAR);
    end
    end_test();

    $display("Ran %0d tests: %0d passed, %0d failed, %0d check errors",
             test_num, pass_cnt, fail_cnt, err_cnt);
    if ((fail_cnt == 0) && (err_cnt == 0)) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
